/* common/ppu_settings.svh */
// ############################
// ppu format settings
// posit width, exponent size and the
// datapath widths derived from them
// ############################
`ifndef PPU_SETTINGS_SVH
`define PPU_SETTINGS_SVH

// posit word width
`define PPU_N 16

// exponent field size, at least one bit
`define PPU_ES 1

// signed scale, wide enough for product scales plus a normalize step
`define PPU_SCALE_W ($clog2(`PPU_N) + `PPU_ES + 3)

// fraction including the hidden bit
`define PPU_FRAC_W (`PPU_N - `PPU_ES - 2)

// double fraction for the product and the aligned sum
`define PPU_WFRAC_W (2 * `PPU_FRAC_W)

`endif

/* common/ppu_pkg.sv */
// ############################
// ppu shared types
// operation codes, request and response
// payloads and the decoded posit form
// ############################
`include "ppu_settings.svh"

package ppu_pkg;

  // arithmetic operations of the unit
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,
    OP_SUB = 2'd1,
    OP_MUL = 2'd2
  } operation_e;

  // one request, two posit operands
  typedef struct packed {
    operation_e        op;
    logic [`PPU_N-1:0] operand_a;
    logic [`PPU_N-1:0] operand_b;
  } ppu_req_t;

  // one rounded posit result
  typedef struct packed {
    logic [`PPU_N-1:0] result;
  } ppu_rsp_t;

  // decoded posit
  // fraction carries the hidden bit at its msb, clear for zero
  typedef struct packed {
    logic                          sign;
    logic                          is_zero;
    logic                          is_nar;
    logic signed [`PPU_SCALE_W-1:0] scale;
    logic [`PPU_FRAC_W-1:0]        fraction;
  } unpacked_posit_t;

endpackage : ppu_pkg

/* source/pipe_stage.sv */
// ############################
// valid/ready register slice
// single entry, full throughput,
// generic payload type
// ############################
module pipe_stage #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic valid_q;
  T     data_q;

  // free slot or the held item leaves this cycle
  assign ready_o = !valid_q || ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      // takes a new item or drains to empty
      valid_q <= valid_i;
    end
  end

  // payload only moves on an accepted transfer
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

  // a refused item stays offered and unchanged upstream
  a_hold_stable: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !ready_o |=> valid_i && $stable(data_i)
  );

  // valid is always known once out of reset
  a_valid_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !$isunknown(valid_o)
  );

endmodule : pipe_stage

/* ppu/posit_decoder.sv */
// ############################
// posit decoder
// splits a posit into sign, scale and
// fraction, flags zero and NaR
// ############################
`include "ppu_settings.svh"

module posit_decoder (
  input  logic [`PPU_N-1:0]        posit_i,
  output ppu_pkg::unpacked_posit_t unpacked_o
);

  localparam int N     = `PPU_N;
  localparam int ES    = `PPU_ES;
  localparam int SW    = `PPU_SCALE_W;
  localparam int FW    = `PPU_FRAC_W;
  localparam int RUN_W = $clog2(N) + 1;

  logic                 is_zero;
  logic                 is_nar;
  logic [N-1:0]         abs_word;
  logic [N-2:0]         body;
  logic                 regime_bit;
  logic [RUN_W-1:0]     run_len;
  logic                 run_done;
  logic signed [SW-1:0] k_val;
  logic [N-2:0]         rest;
  logic [ES-1:0]        exp_bits;

  // the two patterns with no regime
  assign is_zero = (posit_i == '0);
  assign is_nar  = (posit_i == {1'b1, {(N-1){1'b0}}});

  // negative posits decode from their two's complement
  assign abs_word   = posit_i[N-1] ? -posit_i : posit_i;
  assign body       = abs_word[N-2:0];
  assign regime_bit = body[N-2];

  // length of the leading run of identical regime bits
  always_comb begin
    run_len  = '0;
    run_done = 1'b0;
    for (int i = N - 2; i >= 0; i--) begin
      if (!run_done && (body[i] == regime_bit)) begin
        run_len = run_len + 1'b1;
      end else begin
        run_done = 1'b1;
      end
    end
  end

  // ones run gives k = run - 1, zeros run gives k = -run
  assign k_val = regime_bit ? (SW'(run_len) - SW'(1)) : -SW'(run_len);

  // drop regime and terminator, zeros shift in for cut exponent bits
  assign rest     = body << (run_len + 1'b1);
  assign exp_bits = rest[N-2 -: ES];

  always_comb begin
    unpacked_o.sign    = posit_i[N-1];
    unpacked_o.is_zero = is_zero;
    unpacked_o.is_nar  = is_nar;
    // scale = k * 2^es + e
    unpacked_o.scale   = (k_val <<< ES) + $signed({1'b0, exp_bits});
    // hidden one only for a nonzero value
    unpacked_o.fraction = {~is_zero, rest[N-2-ES -: FW-1]};
  end

endmodule : posit_decoder

/* ppu/posit_encoder.sv */
// ############################
// posit encoder
// packs sign, scale and fraction into
// a posit, round to nearest even
// ############################
`include "ppu_settings.svh"

module posit_encoder (
  input  logic                           sign_i,
  input  logic                           is_zero_i,
  input  logic                           is_nar_i,
  input  logic signed [`PPU_SCALE_W-1:0] scale_i,
  input  logic [`PPU_WFRAC_W-1:0]        frac_i,
  input  logic                           sticky_i,
  output logic [`PPU_N-1:0]              posit_o
);

  localparam int N  = `PPU_N;
  localparam int ES = `PPU_ES;
  localparam int SW = `PPU_SCALE_W;
  localparam int WF = `PPU_WFRAC_W;
  // regime seed, exponent, fraction and room for the longest regime
  localparam int TW = 2 + ES + (WF - 1) + N;

  // scale of maxpos, minpos mirrors it
  localparam logic signed [SW-1:0] MAX_SCALE = SW'((N - 2) * (2 ** ES));
  localparam logic signed [SW-1:0] MIN_SCALE = -MAX_SCALE;

  logic signed [SW-1:0] k_val;
  logic [SW-1:0]        shamt;
  logic [ES-1:0]        exp_bits;
  logic                 regime_bit;
  logic [TW-1:0]        seed;
  logic [TW-1:0]        shifted;
  logic [N-2:0]         body;
  logic                 guard;
  logic                 sticky_all;
  logic                 round_up;
  logic [N-2:0]         body_rnd;
  logic [N-1:0]         mag;

  // floor division by 2^es, remainder is the exponent field
  assign k_val    = scale_i >>> ES;
  assign exp_bits = scale_i[ES-1:0];

  // ones for k >= 0, zeros for negative k
  assign regime_bit = ~k_val[SW-1];

  // extra regime bits past the two-bit seed
  assign shamt = k_val[SW-1] ? ~k_val : k_val;

  // seed holds first regime bit and terminator, hidden bit dropped
  assign seed    = {regime_bit, ~regime_bit, exp_bits, frac_i[WF-2:0], {N{1'b0}}};
  // arithmetic shift repeats the regime bit
  assign shifted = $signed(seed) >>> shamt;

  // top n-1 bits form the unsigned posit body
  assign body       = shifted[TW-1 -: N-1];
  assign guard      = shifted[TW-N];
  assign sticky_all = (|shifted[TW-N-1:0]) | sticky_i;

  // ties go to an even body
  assign round_up = guard & (sticky_all | body[0]);
  assign body_rnd = body + {{(N-2){1'b0}}, round_up};

  always_comb begin
    // never round past maxpos or down to zero
    if (scale_i >= MAX_SCALE) begin
      mag = {1'b0, {(N-1){1'b1}}};
    end else if (scale_i < MIN_SCALE) begin
      mag = {{(N-1){1'b0}}, 1'b1};
    end else begin
      mag = {1'b0, body_rnd};
    end

    // specials win over the computed word
    if (is_nar_i) begin
      posit_o = {1'b1, {(N-1){1'b0}}};
    end else if (is_zero_i) begin
      posit_o = '0;
    end else if (sign_i) begin
      posit_o = -mag;
    end else begin
      posit_o = mag;
    end
  end

endmodule : posit_encoder

/* ppu/ppu_core.sv */
// ############################
// ppu arithmetic core
// stage one decodes and computes,
// stage two encodes and rounds
// ############################
`include "ppu_settings.svh"

module ppu_core (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  input  ppu_pkg::ppu_req_t  req_i,
  output logic               rsp_valid_o,
  input  logic               rsp_ready_i,
  output ppu_pkg::ppu_rsp_t  rsp_o
);

  localparam int SW    = `PPU_SCALE_W;
  localparam int FW    = `PPU_FRAC_W;
  localparam int WF    = `PPU_WFRAC_W;
  localparam int SUM_W = WF + 1;
  localparam int LZ_W  = $clog2(SUM_W) + 1;

  ppu_pkg::unpacked_posit_t dec_a;
  ppu_pkg::unpacked_posit_t dec_b;
  ppu_pkg::unpacked_posit_t b_eff;
  ppu_pkg::unpacked_posit_t op_big;
  ppu_pkg::unpacked_posit_t op_sml;

  logic                 a_is_big;
  logic                 eff_sub;
  logic [SW-1:0]        scale_diff;
  logic [WF-1:0]        big_field;
  logic [WF-1:0]        sml_field;
  logic [WF-1:0]        sml_aligned;
  logic                 align_sticky;
  logic [SUM_W-1:0]     sum;
  logic [LZ_W-1:0]      lzc;
  logic                 lz_found;
  logic [SUM_W-1:0]     sum_norm;
  logic [WF-1:0]        product;

  logic                 res_sign;
  logic                 res_zero;
  logic                 res_nar;
  logic                 res_sticky;
  logic signed [SW-1:0] res_scale;
  logic [WF-1:0]        res_frac;

  logic                 s1_ready;
  logic                 s2_ready;
  logic                 s1_load;
  logic                 s2_load;
  logic                 s1_valid_q;
  logic                 s1_sign_q;
  logic                 s1_zero_q;
  logic                 s1_nar_q;
  logic                 s1_sticky_q;
  logic signed [SW-1:0] s1_scale_q;
  logic [WF-1:0]        s1_frac_q;
  logic                 s2_valid_q;
  ppu_pkg::ppu_rsp_t    s2_rsp_q;
  logic [`PPU_N-1:0]    enc_posit;

  posit_decoder u_dec_a (
    .posit_i    (req_i.operand_a),
    .unpacked_o (dec_a)
  );

  posit_decoder u_dec_b (
    .posit_i    (req_i.operand_b),
    .unpacked_o (dec_b)
  );

  // subtract is add with b negated
  always_comb begin
    b_eff      = dec_b;
    b_eff.sign = dec_b.sign ^ (req_i.op == ppu_pkg::OP_SUB);
  end

  // larger magnitude first
  // zero decodes below every real scale
  assign a_is_big = (dec_a.scale > b_eff.scale) ||
                    ((dec_a.scale == b_eff.scale) && (dec_a.fraction >= b_eff.fraction));
  assign op_big   = a_is_big ? dec_a : b_eff;
  assign op_sml   = a_is_big ? b_eff : dec_a;
  assign eff_sub  = op_big.sign ^ op_sml.sign;

  // align the smaller operand with shifted-out bits in sticky
  assign scale_diff   = op_big.scale - op_sml.scale;
  assign big_field    = {op_big.fraction, {FW{1'b0}}};
  assign sml_field    = {op_sml.fraction, {FW{1'b0}}};
  assign sml_aligned  = sml_field >> scale_diff;
  assign align_sticky = |(sml_field & ~({WF{1'b1}} << scale_diff));

  // magnitude sum is never negative
  assign sum = eff_sub ? ({1'b0, big_field} - {1'b0, sml_aligned})
                       : ({1'b0, big_field} + {1'b0, sml_aligned});

  // leading zeros of the sum
  always_comb begin
    lzc      = '0;
    lz_found = 1'b0;
    for (int i = SUM_W - 1; i >= 0; i--) begin
      if (!lz_found && !sum[i]) begin
        lzc = lzc + 1'b1;
      end else begin
        lz_found = 1'b1;
      end
    end
  end

  assign sum_norm = sum << lzc;

  // product of two hidden-bit fractions lies in [1, 4)
  assign product = dec_a.fraction * dec_b.fraction;

  always_comb begin
    res_nar = dec_a.is_nar | dec_b.is_nar;
    if (req_i.op == ppu_pkg::OP_MUL) begin
      res_sign   = dec_a.sign ^ dec_b.sign;
      res_zero   = dec_a.is_zero | dec_b.is_zero;
      res_sticky = 1'b0;
      // one-bit normalize on the product msb
      res_scale  = dec_a.scale + dec_b.scale + $signed({1'b0, product[WF-1]});
      res_frac   = product[WF-1] ? product : (product << 1);
    end else begin
      res_sign   = op_big.sign;
      // exact cancellation and zero plus zero
      res_zero   = (sum == '0);
      // lsb falls off only on a carry out
      res_sticky = align_sticky | sum_norm[0];
      res_scale  = op_big.scale + SW'(1) - SW'(lzc);
      res_frac   = sum_norm[SUM_W-1:1];
    end
  end

  // each stage advances when empty or drained
  assign s2_ready    = !s2_valid_q || rsp_ready_i;
  assign s1_ready    = !s1_valid_q || s2_ready;
  assign req_ready_o = s1_ready;
  assign s1_load     = req_valid_i && s1_ready;
  assign s2_load     = s1_valid_q && s2_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid_q <= req_valid_i;
      end
      if (s2_ready) begin
        s2_valid_q <= s1_valid_q;
      end
    end
  end

  // stage one payload
  always_ff @(posedge clk_i) begin
    if (s1_load) begin
      s1_sign_q   <= res_sign;
      s1_zero_q   <= res_zero;
      s1_nar_q    <= res_nar;
      s1_sticky_q <= res_sticky;
      s1_scale_q  <= res_scale;
      s1_frac_q   <= res_frac;
    end
  end

  posit_encoder u_enc (
    .sign_i    (s1_sign_q),
    .is_zero_i (s1_zero_q),
    .is_nar_i  (s1_nar_q),
    .scale_i   (s1_scale_q),
    .frac_i    (s1_frac_q),
    .sticky_i  (s1_sticky_q),
    .posit_o   (enc_posit)
  );

  // stage two holds the rounded result
  always_ff @(posedge clk_i) begin
    if (s2_load) begin
      s2_rsp_q.result <= enc_posit;
    end
  end

  assign rsp_valid_o = s2_valid_q;
  assign rsp_o       = s2_rsp_q;

  // a request refused by a stalled stage one stays offered unchanged
  a_req_hold: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    req_valid_i && !req_ready_o |=> req_valid_i && $stable(req_i)
  );

endmodule : ppu_core

/* ppu/ppu_top.sv */
// ############################
// ppu top level
// core between an input and an output
// valid/ready slice
// ############################
`include "ppu_settings.svh"

module ppu_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 in_valid_i,
  output logic                 in_ready_o,
  input  ppu_pkg::operation_e  op_i,
  input  logic [`PPU_N-1:0]    operand_a_i,
  input  logic [`PPU_N-1:0]    operand_b_i,
  output logic                 out_valid_o,
  input  logic                 out_ready_i,
  output logic [`PPU_N-1:0]    result_o
);

  ppu_pkg::ppu_req_t in_req;
  ppu_pkg::ppu_req_t core_req;
  ppu_pkg::ppu_rsp_t core_rsp;
  ppu_pkg::ppu_rsp_t out_rsp;
  logic              core_req_valid;
  logic              core_req_ready;
  logic              core_rsp_valid;
  logic              core_rsp_ready;

  // bundle the request ports
  assign in_req = '{op: op_i, operand_a: operand_a_i, operand_b: operand_b_i};

  pipe_stage #(
    .T (ppu_pkg::ppu_req_t)
  ) u_in_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (in_req),
    .valid_o (core_req_valid),
    .ready_i (core_req_ready),
    .data_o  (core_req)
  );

  ppu_core u_core (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (core_req_valid),
    .req_ready_o (core_req_ready),
    .req_i       (core_req),
    .rsp_valid_o (core_rsp_valid),
    .rsp_ready_i (core_rsp_ready),
    .rsp_o       (core_rsp)
  );

  // output slice stalls results instead of dropping them
  pipe_stage #(
    .T (ppu_pkg::ppu_rsp_t)
  ) u_out_stage (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (core_rsp_valid),
    .ready_o (core_rsp_ready),
    .data_i  (core_rsp),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_rsp)
  );

  assign result_o = out_rsp.result;

endmodule : ppu_top

/* tb/ppu_tb.sv */
// ############################
// ppu testbench
// directed and random checks against
// a real-valued posit model
// ############################
`include "ppu_settings.svh"

module ppu_tb;

  localparam int N       = `PPU_N;
  localparam int ES      = `PPU_ES;
  localparam int TIMEOUT = 1000;
  localparam int NUM_RND = 200;
  // registers in the input slice, the two core stages and the output slice
  localparam int LATENCY = 4;
  localparam int MAXPOS  = (1 << (N - 1)) - 1;
  localparam logic [N-1:0] NAR = {1'b1, {(N-1){1'b0}}};
  localparam logic [N-1:0] ONE = {2'b01, {(N-2){1'b0}}};

  logic                clk_i;
  logic                rst_n_i;
  logic                in_valid_i;
  logic                in_ready_o;
  ppu_pkg::operation_e op_i;
  logic [N-1:0]        operand_a_i;
  logic [N-1:0]        operand_b_i;
  logic                out_valid_o;
  logic                out_ready_i;
  logic [N-1:0]        result_o;

  integer       seed = 32'h5ef7_40a6;
  int           cycle_cnt = 0;
  logic [N-1:0] expect_q[$];

  ppu_top u_ppu_top (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // edge counter read only at falling edges
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic real pow2(input int s);
    real v;
    v = 1.0;
    for (int i = 0; i < (s < 0 ? -s : s); i++) begin
      v = (s < 0) ? v / 2.0 : v * 2.0;
    end
    return v;
  endfunction

  // value of an nb-bit posit with nb of n or n+1
  function automatic real posit_to_real(input logic [N:0] p, input int nb);
    logic [N:0] mask;
    logic [N:0] w;
    logic       neg;
    logic       r;
    int         pos;
    int         run;
    int         k;
    int         e;
    real        f;
    real        step;
    mask = (N+1)'((1 << nb) - 1);
    w    = p & mask;
    if (w == '0) begin
      return 0.0;
    end
    neg = w[nb-1];
    if (neg) begin
      w = (~w + 1'b1) & mask;
    end
    // regime run after the sign
    r   = w[nb-2];
    run = 0;
    pos = nb - 2;
    while (pos >= 0 && w[pos] == r) begin
      run++;
      pos--;
    end
    k = r ? run - 1 : -run;
    // skip the terminator
    pos--;
    // exponent bits past the end read as zero
    e = 0;
    for (int i = 0; i < ES; i++) begin
      e = e * 2;
      if (pos >= 0 && w[pos]) begin
        e = e + 1;
      end
      pos--;
    end
    f    = 1.0;
    step = 0.5;
    while (pos >= 0) begin
      if (w[pos]) begin
        f = f + step;
      end
      step = step / 2.0;
      pos--;
    end
    f = f * pow2(k * (2 ** ES) + e);
    return neg ? -f : f;
  endfunction

  // nearest posit with ties to the even pattern
  // clamped to the minpos..maxpos range
  function automatic logic [N-1:0] real_to_posit(input real x);
    real          mag;
    real          mid;
    int           lo;
    int           hi;
    int           m;
    logic [N-1:0] p;
    if (x == 0.0) begin
      return '0;
    end
    mag = (x < 0.0) ? -x : x;
    if (mag >= posit_to_real((N+1)'(MAXPOS), N)) begin
      p = N'(MAXPOS);
    end else if (mag <= posit_to_real((N+1)'(1), N)) begin
      p = N'(1);
    end else begin
      // positive patterns are monotonic in value
      lo = 1;
      hi = MAXPOS;
      while (hi - lo > 1) begin
        m = (lo + hi) / 2;
        if (posit_to_real((N+1)'(m), N) <= mag) begin
          lo = m;
        end else begin
          hi = m;
        end
      end
      // midpoint is the one bit longer posit between lo and hi
      mid = posit_to_real((N+1)'(2 * lo + 1), N + 1);
      if (mag > mid) begin
        p = N'(hi);
      end else if (mag < mid) begin
        p = N'(lo);
      end else begin
        p = (lo % 2 == 1) ? N'(hi) : N'(lo);
      end
    end
    return (x < 0.0) ? -p : p;
  endfunction

  function automatic logic [N-1:0] expected_result(input ppu_pkg::operation_e op,
                                                   input logic [N-1:0] a,
                                                   input logic [N-1:0] b);
    real ra;
    real rb;
    real r;
    if (a == NAR || b == NAR) begin
      return NAR;
    end
    ra = posit_to_real({1'b0, a}, N);
    rb = posit_to_real({1'b0, b}, N);
    case (op)
      ppu_pkg::OP_ADD: r = ra + rb;
      ppu_pkg::OP_SUB: r = ra - rb;
      default:         r = ra * rb;
    endcase
    return real_to_posit(r);
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("Error: %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // starts right after a rising edge
  // returns right after the accepting edge
  task automatic send_req(input ppu_pkg::operation_e op, input logic [N-1:0] a,
                          input logic [N-1:0] b, output int accept_edge);
    int waited;
    bit taken;
    waited      = 0;
    taken       = 1'b0;
    in_valid_i  <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    while (!taken) begin
      // handshake read between edges
      @(negedge clk_i);
      if (in_ready_o) begin
        taken       = 1'b1;
        accept_edge = cycle_cnt + 1;
      end else begin
        waited++;
        if (waited > TIMEOUT) begin
          stop_with_failure("timed out waiting for in_ready_o to rise");
        end
      end
      @(posedge clk_i);
    end
  endtask

  // reports the edge on which the result transfers
  task automatic get_rsp(output logic [N-1:0] result, output int seen_edge);
    int waited;
    bit got;
    waited = 0;
    got    = 1'b0;
    while (!got) begin
      @(negedge clk_i);
      if (out_valid_o && out_ready_i) begin
        got       = 1'b1;
        result    = result_o;
        seen_edge = cycle_cnt + 1;
      end else begin
        waited++;
        if (waited > TIMEOUT) begin
          stop_with_failure("timed out waiting for a result on out_valid_o");
        end
      end
      @(posedge clk_i);
    end
  endtask

  // one request alone in the pipe
  task automatic run_single(input string name, input ppu_pkg::operation_e op,
                            input logic [N-1:0] a, input logic [N-1:0] b);
    int           acc;
    int           seen;
    logic [N-1:0] res;
    logic [N-1:0] exp_val;
    exp_val = expected_result(op, a, b);
    send_req(op, a, b, acc);
    in_valid_i <= 1'b0;
    get_rsp(res, seen);
    check_value(name, exp_val, res);
  endtask

  task automatic random_operand(output logic [N-1:0] p);
    int  r;
    int  s;
    real v;
    r = $random(seed);
    s = $random(seed) % 17;
    if (r[5:0] == 6'd0) begin
      p = '0;
    end else if (r[5:0] == 6'd1) begin
      p = NAR;
    end else begin
      // twelve fraction bits and a scale within sixteen keep sums exact
      v = (1.0 + real'(r[19:8]) / 4096.0) * pow2(s);
      p = real_to_posit(r[31] ? -v : v);
    end
  endtask

  task automatic test_reset();
    @(negedge clk_i);
    check_value("test_reset out_valid_o", 0, out_valid_o);
    check_value("test_reset in_ready_o", 1, in_ready_o);
    @(posedge clk_i);
  endtask

  task automatic test_mul_directed();
    // model sanity on the unit pattern
    check_value("test_mul_directed model", ONE, real_to_posit(1.0));
    run_single("test_mul_directed 1x1", ppu_pkg::OP_MUL, ONE, ONE);
    run_single("test_mul_directed 2x0.5", ppu_pkg::OP_MUL,
               real_to_posit(2.0), real_to_posit(0.5));
    run_single("test_mul_directed -1.5x3", ppu_pkg::OP_MUL,
               real_to_posit(-1.5), real_to_posit(3.0));
    run_single("test_mul_directed maxposx2", ppu_pkg::OP_MUL,
               N'(MAXPOS), real_to_posit(2.0));
    run_single("test_mul_directed zero", ppu_pkg::OP_MUL, '0, real_to_posit(5.25));
    run_single("test_mul_directed nar", ppu_pkg::OP_MUL, NAR, real_to_posit(3.0));
  endtask

  task automatic test_add_sub_directed();
    run_single("test_add_sub_directed add", ppu_pkg::OP_ADD,
               real_to_posit(1.5), real_to_posit(2.25));
    // exact cancellation both ways
    run_single("test_add_sub_directed sub cancel", ppu_pkg::OP_SUB,
               real_to_posit(3.75), real_to_posit(3.75));
    run_single("test_add_sub_directed add cancel", ppu_pkg::OP_ADD,
               real_to_posit(-0.625), real_to_posit(0.625));
    run_single("test_add_sub_directed sub scales", ppu_pkg::OP_SUB,
               real_to_posit(4.0), real_to_posit(0.75));
    run_single("test_add_sub_directed sub small big", ppu_pkg::OP_SUB,
               real_to_posit(0.1), real_to_posit(96.0));
    run_single("test_add_sub_directed add zero", ppu_pkg::OP_ADD,
               '0, real_to_posit(-7.5));
    run_single("test_add_sub_directed add nar", ppu_pkg::OP_ADD, ONE, NAR);
    run_single("test_add_sub_directed sub nar", ppu_pkg::OP_SUB, NAR, NAR);
  endtask

  task automatic test_latency();
    int           acc;
    int           seen;
    logic [N-1:0] res;
    send_req(ppu_pkg::OP_ADD, ONE, real_to_posit(0.5), acc);
    in_valid_i <= 1'b0;
    get_rsp(res, seen);
    check_value("test_latency edge", acc + LATENCY, seen);
    check_value("test_latency value", real_to_posit(1.5), res);
  endtask

  task automatic test_random_backpressure();
    ppu_pkg::operation_e op;
    logic [N-1:0]        a;
    logic [N-1:0]        b;
    logic [N-1:0]        res;
    logic [N-1:0]        exp_val;
    int                  sel;
    int                  acc;
    int                  seen;
    int                  rnd;
    bit                  done;
    done = 1'b0;
    fork
      begin
        for (int i = 0; i < NUM_RND; i++) begin
          random_operand(a);
          random_operand(b);
          sel = $unsigned($random(seed)) % 3;
          op  = (sel == 0) ? ppu_pkg::OP_ADD : (sel == 1) ? ppu_pkg::OP_SUB : ppu_pkg::OP_MUL;
          expect_q.push_back(expected_result(op, a, b));
          send_req(op, a, b, acc);
          // idle gap now and then
          if (($random(seed) & 3) == 0) begin
            in_valid_i <= 1'b0;
            @(posedge clk_i);
          end
        end
        in_valid_i <= 1'b0;
      end
      begin
        for (int i = 0; i < NUM_RND; i++) begin
          get_rsp(res, seen);
          if (expect_q.size() == 0) begin
            stop_with_failure("a result arrived with no request outstanding");
          end
          exp_val = expect_q.pop_front();
          check_value("test_random_backpressure", exp_val, res);
        end
        done = 1'b1;
      end
      begin
        // random stalls at the output
        while (!done) begin
          @(posedge clk_i);
          rnd = $random(seed);
          out_ready_i <= rnd[0];
        end
      end
    join
    out_ready_i <= 1'b1;
    // no extra results trail the last one
    for (int i = 0; i < 20; i++) begin
      @(negedge clk_i);
      check_value("test_random_backpressure extra", 0, out_valid_o);
    end
    @(posedge clk_i);
  endtask

  initial begin
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    op_i        = ppu_pkg::OP_ADD;
    operand_a_i = '0;
    operand_b_i = '0;
    out_ready_i = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    test_reset();
    test_mul_directed();
    test_add_sub_directed();
    test_latency();
    test_random_backpressure();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule : ppu_tb

/* all.f */
+incdir+common
common/ppu_pkg.sv
source/pipe_stage.sv
ppu/posit_decoder.sv
ppu/posit_encoder.sv
ppu/ppu_core.sv
ppu/ppu_top.sv
tb/ppu_tb.sv

/* run.sh */
#!/bin/sh
# build the ppu testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module ppu_tb -f all.f -o ppu_sim &&
./obj_dir/ppu_sim | grep "ALL CHECKS PASSED" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
